// File: files.f
verilog/rv32e_pkg.sv
verilog/pc_unit.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/rv32e_core.sv
verif/tb_rv32e_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rv32e core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv32e_core -f files.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// File: verif/tb_rv32e_core.sv
`timescale 1ns/1ps

module tb_rv32e_core;

    localparam int prog_words = 256;
    localparam logic [31:0] trap_base = 32'h0000_0300;  // handler location, also mtvec

    logic               clk;
    logic               rst;
    logic [31:0]        inst;
    logic [31:0]        pc;
    rv32e_pkg::retire_t retire;
    logic               illegal_inst;

    logic [31:0] prog [prog_words];
    int          wr_idx;
    int          prog_len;
    int          cycle_limit;
    logic [31:0] end_pc;
    logic [31:0] lcg_state;
    logic        timed_out;
    int          cycle = 0;
    int          errors = 0;

    // reference model state
    logic [31:0] m_gpr [16];
    logic [31:0] m_csr [4];  // mstatus, mtvec, mepc, mcause
    logic [31:0] m_pc;

    // expected effect of the instruction on the bus
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] imm_i;
    logic [2:0]  slot;
    logic        exp_ill;
    logic        exp_wr;
    logic [31:0] exp_data;
    logic [31:0] exp_next;
    logic        exp_csr_wr;
    logic [31:0] exp_csr_val;
    logic        exp_trap;

    rv32e_core rv32e_core_inst (
        .clk          (clk),
        .rst          (rst),
        .inst         (inst),
        .pc           (pc),
        .retire       (retire),
        .illegal_inst (illegal_inst)
    );

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [3:0] rs1,
                                               input logic [2:0] f3, input logic [3:0] rd,
                                               input logic [6:0] opc);
        return {imm, 1'b0, rs1, f3, 1'b0, rd, opc};
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [3:0] rs2,
                                               input logic [3:0] rs1, input logic [2:0] f3,
                                               input logic [3:0] rd);
        return {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] utype_word(input logic [19:0] imm, input logic [3:0] rd);
        return {imm, 1'b0, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // {known, slot} for a CSR address
    function automatic logic [2:0] csr_slot(input logic [11:0] addr);
        case (addr)
            12'h300: return 3'b100;
            12'h305: return 3'b101;
            12'h341: return 3'b110;
            12'h342: return 3'b111;
            default: return 3'b000;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[wr_idx] = word;
        wr_idx++;
        prog_len++;
    endtask

    task automatic build_program();
        logic [31:0] r;
        int          kind;
        int          main_idx;
        wr_idx   = 0;
        prog_len = 0;
        for (int i = 0; i < prog_words; i++) begin
            prog[i] = utype_word(20'(i), 4'd0);  // lui x0 filler tagged with its index
        end
        emit(itype_word(12'h300, 4'd0, 3'b010, 4'd1, 7'b1110011));  // csrrs x1, mstatus, x0
        emit(itype_word(12'h342, 4'd0, 3'b010, 4'd2, 7'b1110011));  // csrrs x2, mcause, x0
        for (int i = 0; i < 48; i++) begin
            r    = next_rand();
            kind = int'(r[31:28]) % 10;
            case (kind)
                0: emit(itype_word(r[11:0], r[23:20], 3'b000, r[19:16], 7'b0010011));
                1: emit(itype_word(r[11:0], r[23:20], 3'b111, r[19:16], 7'b0010011));
                2: emit(itype_word(r[11:0], r[23:20], 3'b110, r[19:16], 7'b0010011));
                3: emit(itype_word(r[11:0], r[23:20], 3'b100, r[19:16], 7'b0010011));
                4: emit(rtype_word(7'b0000000, r[27:24], r[23:20], 3'b000, r[19:16]));
                5: emit(rtype_word(7'b0100000, r[27:24], r[23:20], 3'b000, r[19:16]));
                6: emit(rtype_word(7'b0000000, r[27:24], r[23:20], 3'b111, r[19:16]));
                7: emit(rtype_word(7'b0000000, r[27:24], r[23:20], 3'b110, r[19:16]));
                8: emit(rtype_word(7'b0000000, r[27:24], r[23:20], 3'b100, r[19:16]));
                default: emit(utype_word(r[31:12], r[19:16]));
            endcase
        end
        emit(itype_word(12'h555, 4'd5, 3'b000, 4'd0, 7'b0010011));  // writes to x0
        emit(utype_word(20'habcde, 4'd0));
        emit(rtype_word(7'b0000000, 4'd0, 4'd0, 3'b000, 4'd3));    // x0 reads back zero
        emit(itype_word(12'h000, 4'd0, 3'b110, 4'd4, 7'b0010011));
        for (int i = 1; i < 16; i++) begin
            emit(itype_word(12'h000, 4'(i), 3'b000, 4'(i), 7'b0010011));  // readback
        end
        // mtvec ends up at trap_base
        emit(itype_word(12'h200, 4'd0, 3'b000, 4'd5, 7'b0010011));
        emit(itype_word(12'h305, 4'd5, 3'b001, 4'd6, 7'b1110011));
        emit(itype_word(12'h305, 4'd0, 3'b010, 4'd7, 7'b1110011));
        emit(itype_word(12'h100, 4'd0, 3'b000, 4'd8, 7'b0010011));
        emit(itype_word(12'h305, 4'd8, 3'b010, 4'd9, 7'b1110011));
        emit(itype_word(12'h305, 4'd0, 3'b010, 4'd10, 7'b1110011));
        emit(itype_word(12'h07c, 4'd0, 3'b000, 4'd11, 7'b0010011));
        emit(itype_word(12'h341, 4'd11, 3'b001, 4'd12, 7'b1110011));
        emit(itype_word(12'h341, 4'd0, 3'b010, 4'd13, 7'b1110011));
        emit(itype_word(12'h342, 4'd0, 3'b001, 4'd14, 7'b1110011));  // mcause cleared before the trap
        emit(32'h0000_0073);  // ecall
        main_idx = wr_idx;
        wr_idx   = int'(trap_base >> 2);
        emit(itype_word(12'h341, 4'd0, 3'b010, 4'd1, 7'b1110011));
        emit(itype_word(12'h342, 4'd0, 3'b010, 4'd2, 7'b1110011));
        emit(itype_word(12'h004, 4'd1, 3'b000, 4'd1, 7'b0010011));  // skip past the ecall
        emit(itype_word(12'h341, 4'd1, 3'b001, 4'd0, 7'b1110011));
        emit(32'h3020_0073);  // mret
        wr_idx = main_idx;
        emit(itype_word(12'h010, 4'd5, 3'b010, 4'd3, 7'b0000011));  // lw, not supported
        emit(itype_word(12'h7c0, 4'd5, 3'b001, 4'd4, 7'b1110011));  // unknown csr
        emit(itype_word(12'h000, 4'd3, 3'b000, 4'd3, 7'b0010011));
        emit(itype_word(12'h000, 4'd4, 3'b000, 4'd4, 7'b0010011));
        emit(itype_word(12'h300, 4'd0, 3'b010, 4'd6, 7'b1110011));  // mstatus still at reset
        end_pc = 32'(wr_idx) << 2;
    endtask

    always_comb begin
        src1        = m_gpr[inst[18:15]];
        src2        = m_gpr[inst[23:20]];
        imm_i       = {{20{inst[31]}}, inst[31:20]};
        slot        = csr_slot(inst[31:20]);
        exp_ill     = 1'b0;
        exp_wr      = 1'b0;
        exp_data    = '0;
        exp_next    = m_pc + 32'd4;
        exp_csr_wr  = 1'b0;
        exp_csr_val = '0;
        exp_trap    = 1'b0;
        case (inst[6:0])
            7'b0110111: begin
                exp_wr   = 1'b1;
                exp_data = {inst[31:12], 12'b0};
            end
            7'b0010011: begin
                exp_wr = 1'b1;
                case (inst[14:12])
                    3'b000:  exp_data = src1 + imm_i;
                    3'b100:  exp_data = src1 ^ imm_i;
                    3'b110:  exp_data = src1 | imm_i;
                    3'b111:  exp_data = src1 & imm_i;
                    default: exp_ill = 1'b1;
                endcase
            end
            7'b0110011: begin
                exp_wr = 1'b1;
                case ({inst[31:25], inst[14:12]})
                    10'b0000000_000: exp_data = src1 + src2;
                    10'b0100000_000: exp_data = src1 - src2;
                    10'b0000000_100: exp_data = src1 ^ src2;
                    10'b0000000_110: exp_data = src1 | src2;
                    10'b0000000_111: exp_data = src1 & src2;
                    default:         exp_ill = 1'b1;
                endcase
            end
            7'b1110011: begin
                if (inst == 32'h0000_0073) begin
                    exp_trap = 1'b1;
                    exp_next = m_csr[1];
                end else if (inst == 32'h3020_0073) begin
                    exp_next = m_csr[2];
                end else if ((inst[14:12] == 3'b001 || inst[14:12] == 3'b010) && slot[2]) begin
                    exp_wr      = 1'b1;
                    exp_data    = m_csr[slot[1:0]];  // old value
                    exp_csr_wr  = 1'b1;
                    exp_csr_val = inst[12] ? src1 : (m_csr[slot[1:0]] | src1);
                end else begin
                    exp_ill = 1'b1;
                end
            end
            default: exp_ill = 1'b1;
        endcase
        if (exp_ill) begin
            exp_wr     = 1'b0;
            exp_csr_wr = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                m_gpr[i] <= '0;
            end
            m_csr[0] <= 32'h0000_1800;
            m_csr[1] <= '0;
            m_csr[2] <= '0;
            m_csr[3] <= 32'd11;
            m_pc     <= '0;
        end else begin
            if (exp_wr && inst[10:7] != 4'd0) begin
                m_gpr[inst[10:7]] <= exp_data;
            end
            if (exp_csr_wr) begin
                m_csr[slot[1:0]] <= exp_csr_val;
            end
            if (exp_trap) begin
                m_csr[2] <= m_pc;
                m_csr[3] <= 32'd11;
            end
            m_pc <= exp_next;
        end
    end

    reset_state: assert property (@(posedge clk)
        !(rst && cycle > 0) || (pc == '0 && !retire.valid && !illegal_inst))
        else begin
            errors++;
            $display("[ERROR] %0d ns: pc, retire.valid or illegal_inst wrong in reset", $time);
        end

    pc_flow: assert property (@(posedge clk) disable iff (rst) pc == m_pc)
        else begin
            errors++;
            $display("[ERROR] %0d ns: pc %h, model expects %h", $time,
                     $sampled(pc), $sampled(m_pc));
        end

    retire_match: assert property (@(posedge clk) disable iff (rst)
        retire.valid && retire.pc == m_pc && retire.rd_wr == exp_wr &&
        (!exp_wr || (retire.rd == inst[10:7] && retire.rd_data == exp_data)))
        else begin
            errors++;
            $display("[ERROR] %0d ns: retire mismatch for instruction %h", $time, inst);
        end

    illegal_flag: assert property (@(posedge clk) disable iff (rst) illegal_inst == exp_ill)
        else begin
            errors++;
            $display("[ERROR] %0d ns: illegal_inst wrong for instruction %h", $time, inst);
        end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst       = 1'b1;
        inst      = 32'h0000_0013;  // nop until the first fetch
        timed_out = 1'b0;
        lcg_state = 32'hac48_d22b;
        build_program();
        cycle_limit = 2 * prog_len + 20;
        repeat (4) begin
            @(negedge clk);
            inst = prog[pc[9:2]];
        end
        rst = 1'b0;
        while (pc != end_pc && cycle < cycle_limit) begin
            @(negedge clk);
            inst = prog[pc[9:2]];
        end
        if (pc != end_pc) begin
            timed_out = 1'b1;
            $display("timeout: program end not reached within %0d cycles", cycle_limit);
        end
        $display("run finished after %0d cycles with %0d errors", cycle, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  rv32e_pkg::ctrl_t           ctrl,
    input  logic [rv32e_pkg::xlen-1:0] rs1_data,
    input  logic [rv32e_pkg::xlen-1:0] rs2_data,
    input  logic [rv32e_pkg::xlen-1:0] csr_rdata,
    output logic [rv32e_pkg::xlen-1:0] rd_data,
    output logic [rv32e_pkg::xlen-1:0] csr_wdata
);

    logic [rv32e_pkg::xlen-1:0] op_b;
    logic [rv32e_pkg::xlen-1:0] alu_res;

    assign op_b = ctrl.use_imm ? ctrl.imm : rs2_data;

    always_comb begin
        case (ctrl.alu_op)
            rv32e_pkg::alu_add:    alu_res = rs1_data + op_b;
            rv32e_pkg::alu_sub:    alu_res = rs1_data - op_b;
            rv32e_pkg::alu_and:    alu_res = rs1_data & op_b;
            rv32e_pkg::alu_or:     alu_res = rs1_data | op_b;
            rv32e_pkg::alu_xor:    alu_res = rs1_data ^ op_b;
            rv32e_pkg::alu_pass_b: alu_res = op_b;  // lui
            default:               alu_res = rs1_data + op_b;
        endcase
    end

    // csr instructions return the old value in rd
    always_comb begin
        case (ctrl.csr_op)
            rv32e_pkg::csrop_write: begin
                rd_data   = csr_rdata;
                csr_wdata = rs1_data;
            end
            rv32e_pkg::csrop_set: begin
                rd_data   = csr_rdata;
                csr_wdata = csr_rdata | rs1_data;
            end
            default: begin
                rd_data   = alu_res;
                csr_wdata = rs1_data;  // not stored outside write and set
            end
        endcase
    end

endmodule

// File: verilog/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  logic [rv32e_pkg::xlen-1:0] inst,
    output rv32e_pkg::ctrl_t           ctrl
);

    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [11:0]                csr_addr;
    logic [rv32e_pkg::xlen-1:0] imm_i;
    logic [rv32e_pkg::xlen-1:0] imm_u;
    logic                       csr_known;
    rv32e_pkg::csr_sel_t        csr_sel;
    logic                       op_ok;    // encoding is in the supported subset
    logic                       idx_bad;  // a used register index is above x15

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign csr_addr = inst[31:20];
    assign imm_i    = {{20{inst[31]}}, inst[31:20]};
    assign imm_u    = {inst[31:12], 12'b0};

    always_comb begin
        csr_known = 1'b1;
        case (csr_addr)
            rv32e_pkg::csr_mstatus: csr_sel = rv32e_pkg::sel_mstatus;
            rv32e_pkg::csr_mtvec:   csr_sel = rv32e_pkg::sel_mtvec;
            rv32e_pkg::csr_mepc:    csr_sel = rv32e_pkg::sel_mepc;
            rv32e_pkg::csr_mcause:  csr_sel = rv32e_pkg::sel_mcause;
            default: begin
                csr_sel   = rv32e_pkg::sel_mstatus;
                csr_known = 1'b0;
            end
        endcase
    end

    always_comb begin
        op_ok        = 1'b0;
        idx_bad      = 1'b0;
        ctrl.rs1     = inst[18:15];  // low four bits only, bit 4 checked below
        ctrl.rs2     = inst[23:20];
        ctrl.rd      = inst[10:7];
        ctrl.imm     = imm_i;
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = rv32e_pkg::alu_add;
        ctrl.csr_op  = rv32e_pkg::csrop_none;
        ctrl.csr_sel = csr_sel;
        ctrl.reg_wr  = 1'b0;

        case (opcode)
            rv32e_pkg::op_lui: begin
                op_ok       = 1'b1;
                idx_bad     = inst[11];
                ctrl.imm    = imm_u;
                ctrl.alu_op = rv32e_pkg::alu_pass_b;
                ctrl.reg_wr = 1'b1;
            end
            rv32e_pkg::op_imm: begin
                op_ok       = 1'b1;
                idx_bad     = inst[11] | inst[19];
                ctrl.reg_wr = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = rv32e_pkg::alu_add;
                    3'b100:  ctrl.alu_op = rv32e_pkg::alu_xor;
                    3'b110:  ctrl.alu_op = rv32e_pkg::alu_or;
                    3'b111:  ctrl.alu_op = rv32e_pkg::alu_and;
                    default: op_ok = 1'b0;  // shifts and compares not supported
                endcase
            end
            rv32e_pkg::op_reg: begin
                op_ok        = 1'b1;
                idx_bad      = inst[11] | inst[19] | inst[24];
                ctrl.use_imm = 1'b0;
                ctrl.reg_wr  = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.alu_op = rv32e_pkg::alu_add;
                    10'b0100000_000: ctrl.alu_op = rv32e_pkg::alu_sub;
                    10'b0000000_100: ctrl.alu_op = rv32e_pkg::alu_xor;
                    10'b0000000_110: ctrl.alu_op = rv32e_pkg::alu_or;
                    10'b0000000_111: ctrl.alu_op = rv32e_pkg::alu_and;
                    default:         op_ok = 1'b0;
                endcase
            end
            rv32e_pkg::op_system: begin
                if (inst == rv32e_pkg::inst_ecall) begin
                    op_ok       = 1'b1;
                    ctrl.csr_op = rv32e_pkg::csrop_ecall;
                end else if (inst == rv32e_pkg::inst_mret) begin
                    op_ok       = 1'b1;
                    ctrl.csr_op = rv32e_pkg::csrop_mret;
                end else if (funct3 == 3'b001 || funct3 == 3'b010) begin
                    op_ok       = csr_known;
                    idx_bad     = inst[11] | inst[19];
                    ctrl.reg_wr = 1'b1;
                    if (funct3 == 3'b001) begin
                        ctrl.csr_op = rv32e_pkg::csrop_write;  // csrrw
                    end else begin
                        ctrl.csr_op = rv32e_pkg::csrop_set;    // csrrs
                    end
                end
            end
            default: ;
        endcase

        // unsupported encodings only move the pc
        ctrl.illegal = !op_ok || idx_bad;
        if (ctrl.illegal) begin
            ctrl.reg_wr = 1'b0;
            ctrl.csr_op = rv32e_pkg::csrop_none;
        end
    end

endmodule

// File: verilog/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  rv32e_pkg::ctrl_t              ctrl,
    input  logic [rv32e_pkg::xlen-1:0]    mtvec,
    input  logic [rv32e_pkg::xlen-1:0]    mepc,
    output logic [rv32e_pkg::xlen-1:0]    pc
);

    logic [rv32e_pkg::xlen-1:0] pc_q;
    logic [rv32e_pkg::xlen-1:0] pc_next;

    // trap vector, return address or fall through
    always_comb begin
        case (ctrl.csr_op)
            rv32e_pkg::csrop_ecall: pc_next = mtvec;
            rv32e_pkg::csrop_mret:  pc_next = mepc;
            default:                pc_next = pc_q + 32'd4;  // illegal also lands here
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;  // boot address
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc = pc_q;

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                       clk,
    input  logic                       rst,
    input  rv32e_pkg::ctrl_t           ctrl,
    input  logic [rv32e_pkg::xlen-1:0] pc,
    input  logic [rv32e_pkg::xlen-1:0] rd_data,
    input  logic [rv32e_pkg::xlen-1:0] csr_wdata,
    output logic [rv32e_pkg::xlen-1:0] rs1_data,
    output logic [rv32e_pkg::xlen-1:0] rs2_data,
    output logic [rv32e_pkg::xlen-1:0] csr_rdata,
    output logic [rv32e_pkg::xlen-1:0] mtvec,
    output logic [rv32e_pkg::xlen-1:0] mepc
);

    logic [rv32e_pkg::xlen-1:0] gpr [rv32e_pkg::gpr_num];
    logic [rv32e_pkg::xlen-1:0] csr [rv32e_pkg::csr_num];  // indexed by csr_sel_t

    // general registers, x0 never written so it stays at zero after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rv32e_pkg::gpr_num; i++) begin
                gpr[i] <= '0;
            end
        end else if (ctrl.reg_wr && ctrl.rd != '0) begin
            gpr[ctrl.rd] <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            csr[rv32e_pkg::sel_mstatus] <= rv32e_pkg::mstatus_rst;
            csr[rv32e_pkg::sel_mtvec]   <= '0;
            csr[rv32e_pkg::sel_mepc]    <= '0;
            csr[rv32e_pkg::sel_mcause]  <= rv32e_pkg::mcause_rst;
        end else begin
            case (ctrl.csr_op)
                rv32e_pkg::csrop_write,
                rv32e_pkg::csrop_set: begin
                    csr[ctrl.csr_sel] <= csr_wdata;
                end
                rv32e_pkg::csrop_ecall: begin
                    // trap entry saves the faulting pc and cause together
                    csr[rv32e_pkg::sel_mepc]   <= pc;
                    csr[rv32e_pkg::sel_mcause] <= rv32e_pkg::cause_ecall;
                end
                default: ;  // mret only reads mepc
            endcase
        end
    end

    assign rs1_data  = gpr[ctrl.rs1];
    assign rs2_data  = gpr[ctrl.rs2];
    assign csr_rdata = csr[ctrl.csr_sel];

    // direct taps for next-pc selection
    assign mtvec = csr[rv32e_pkg::sel_mtvec];
    assign mepc  = csr[rv32e_pkg::sel_mepc];

endmodule

// File: verilog/rv32e_core.sv
`timescale 1ns/1ps

module rv32e_core (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [rv32e_pkg::xlen-1:0] inst,
    output logic [rv32e_pkg::xlen-1:0] pc,
    output rv32e_pkg::retire_t         retire,
    output logic                       illegal_inst
);

    rv32e_pkg::ctrl_t           ctrl;
    logic [rv32e_pkg::xlen-1:0] rs1_data;
    logic [rv32e_pkg::xlen-1:0] rs2_data;
    logic [rv32e_pkg::xlen-1:0] csr_rdata;
    logic [rv32e_pkg::xlen-1:0] mtvec;
    logic [rv32e_pkg::xlen-1:0] mepc;
    logic [rv32e_pkg::xlen-1:0] rd_data;
    logic [rv32e_pkg::xlen-1:0] csr_wdata;

    pc_unit pc_unit_inst (
        .clk   (clk),
        .rst   (rst),
        .ctrl  (ctrl),
        .mtvec (mtvec),
        .mepc  (mepc),
        .pc    (pc)
    );

    inst_decode inst_decode_inst (
        .inst (inst),
        .ctrl (ctrl)
    );

    reg_file reg_file_inst (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .pc        (pc),
        .rd_data   (rd_data),
        .csr_wdata (csr_wdata),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .csr_rdata (csr_rdata),
        .mtvec     (mtvec),
        .mepc      (mepc)
    );

    exec_unit exec_unit_inst (
        .ctrl      (ctrl),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .csr_rdata (csr_rdata),
        .rd_data   (rd_data),
        .csr_wdata (csr_wdata)
    );

    // one instruction retires every cycle outside reset
    assign retire.valid   = !rst;
    assign retire.pc      = pc;
    assign retire.rd      = ctrl.rd;
    assign retire.rd_wr   = ctrl.reg_wr;
    assign retire.rd_data = rd_data;

    assign illegal_inst = ctrl.illegal && !rst;

endmodule

// File: verilog/rv32e_pkg.sv
package rv32e_pkg;

    // datapath and register file sizes
    localparam int xlen      = 32;
    localparam int gpr_num   = 16;
    localparam int gpr_idx_w = 4;
    localparam int csr_num   = 4;

    // machine CSR addresses
    localparam logic [11:0] csr_mstatus = 12'h300;
    localparam logic [11:0] csr_mtvec   = 12'h305;
    localparam logic [11:0] csr_mepc    = 12'h341;
    localparam logic [11:0] csr_mcause  = 12'h342;

    localparam logic [xlen-1:0] mstatus_rst = 32'h0000_1800;  // MPP = machine
    localparam logic [xlen-1:0] mcause_rst  = 32'h0000_000b;
    localparam logic [xlen-1:0] cause_ecall = 32'd11;         // ecall from M-mode

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    // full system encodings without operands
    localparam logic [xlen-1:0] inst_ecall = 32'h0000_0073;
    localparam logic [xlen-1:0] inst_mret  = 32'h3020_0073;

    // internal CSR slot, also the index into the CSR array
    typedef enum logic [1:0] {
        sel_mstatus = 2'd0,
        sel_mtvec   = 2'd1,
        sel_mepc    = 2'd2,
        sel_mcause  = 2'd3
    } csr_sel_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b  // lui
    } alu_op_t;

    typedef enum logic [2:0] {
        csrop_none,
        csrop_write,
        csrop_set,
        csrop_ecall,
        csrop_mret
    } csr_op_t;

    typedef struct packed {
        logic [gpr_idx_w-1:0] rs1;
        logic [gpr_idx_w-1:0] rs2;
        logic [gpr_idx_w-1:0] rd;
        logic [xlen-1:0]      imm;
        logic                 use_imm;
        alu_op_t              alu_op;
        csr_op_t              csr_op;
        csr_sel_t             csr_sel;
        logic                 reg_wr;
        logic                 illegal;
    } ctrl_t;

    // instruction completing this cycle
    typedef struct packed {
        logic                 valid;
        logic [xlen-1:0]      pc;
        logic [gpr_idx_w-1:0] rd;
        logic                 rd_wr;
        logic [xlen-1:0]      rd_data;
    } retire_t;

endpackage
